//--- arcade_ctl_top.f
src/ctl_pkg.sv
src/cab_pkg.sv
src/stick_if.sv
src/input_capture.sv
src/stick_lane.sv
src/cabinet_packer.sv
src/audio_dac.sv
src/arcade_ctl_top.sv
verif/tb_arcade_ctl.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of tb_arcade_ctl

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f arcade_ctl_top.f \
	--top-module tb_arcade_ctl -o tb_arcade_ctl > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/tb_arcade_ctl > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "simulation failed"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "simulator exited with status $run_status"
	exit 1
fi
exit 0

//--- src/arcade_ctl_top.sv
/*
 * Arcade control top level: input capture, per-source stick lanes,
 * cabinet packer and audio DAC
 */
`timescale 1ns/1ps

module arcade_ctl_top import ctl_pkg::*, cab_pkg::*; #(
	parameter int SYNC_STAGES = sync_stages_def,
	parameter int NUM_SRC     = num_src,
	parameter int AUDIO_W     = audio_w_def
) (
	input  logic               clk_sys,
	input  logic               arst_n,
	input  logic               key_strobe,
	input  logic               key_pressed,
	input  logic [7:0]         key_code,
	input  logic [7:0]         joystick_0,
	input  logic [7:0]         joystick_1,
	input  logic               rotate,
	input  logic [AUDIO_W-1:0] audio,
	output logic [7:0]         in0,
	output logic [7:0]         in1,
	output logic               audio_out
);

	stick_if raw_stick [NUM_SRC] ();
	stick_if lane_stick [NUM_SRC] ();

	logic kbd_coin, kbd_start1, kbd_start2;

	// ========================================
	// Controls
	// ========================================
	input_capture #(.SYNC_STAGES(SYNC_STAGES)) u_capture (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.key_strobe (key_strobe),
		.key_pressed(key_pressed),
		.key_code   (key_code),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.raw_stick  (raw_stick),
		.kbd_coin   (kbd_coin),
		.kbd_start1 (kbd_start1),
		.kbd_start2 (kbd_start2)
	);

	for (genvar i = 0; i < NUM_SRC; i++) begin : g_lane
		stick_lane u_lane (
			.clk_sys  (clk_sys),
			.arst_n   (arst_n),
			.rotate   (rotate),
			.stick_in (raw_stick[i]),
			.stick_out(lane_stick[i])
		);
	end

	cabinet_packer #(.NUM_SRC(NUM_SRC)) u_packer (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.kbd_coin  (kbd_coin),
		.kbd_start1(kbd_start1),
		.kbd_start2(kbd_start2),
		.lanes     (lane_stick),
		.in0       (in0),
		.in1       (in1)
	);

	// Sound
	audio_dac #(.AUDIO_W(AUDIO_W)) u_dac (
		.clk_sys(clk_sys),
		.arst_n (arst_n),
		.sample (audio),
		.dac_out(audio_out)
	);

endmodule

//--- src/audio_dac.sv
/*
 * First-order sigma-delta DAC with a one-bit registered output
 */
`timescale 1ns/1ps

module audio_dac import cab_pkg::*; #(
	parameter int AUDIO_W = audio_w_def
) (
	input  logic               clk_sys,
	input  logic               arst_n,
	input  logic [AUDIO_W-1:0] sample,
	output logic               dac_out
);

	logic [AUDIO_W-1:0] acc;
	logic [AUDIO_W:0]   sum; // Carry in the top bit

	assign sum = {1'b0, acc} + {1'b0, sample};

	// Carry rate over 2^AUDIO_W cycles equals the sample value
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			acc     <= '0;
			dac_out <= 1'b0;
		end else begin
			acc     <= sum[AUDIO_W-1:0];
			dac_out <= sum[AUDIO_W];
		end
	end

endmodule

//--- src/cab_pkg.sv
/*
 * Cabinet package: in0 and in1 bit positions, used-bit masks,
 * default audio sample width
 */
package cab_pkg;

	// in0 register, active low on the board
	localparam int in0_up    = 0;
	localparam int in0_left  = 1;
	localparam int in0_right = 2;
	localparam int in0_down  = 3;
	localparam int in0_coin  = 5;

	// in1 register, active low on the board
	localparam int in1_fire   = 4;
	localparam int in1_start1 = 5;
	localparam int in1_start2 = 6;

	// Bits the game reads; everything else idles high
	localparam logic [7:0] in0_used_mask = 8'b0010_1111;
	localparam logic [7:0] in1_used_mask = 8'b0111_0000;

	// Sound sample width from the game board
	localparam int audio_w_def = 8;

endpackage

//--- src/cabinet_packer.sv
/*
 * Cabinet packer: OR of all stick lanes plus keyboard buttons
 * into the registered active-low in0 and in1 words
 */
`timescale 1ns/1ps

module cabinet_packer import ctl_pkg::*, cab_pkg::*; #(
	parameter int NUM_SRC = num_src
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       kbd_coin,
	input  logic       kbd_start1,
	input  logic       kbd_start2,
	stick_if.dst       lanes [NUM_SRC],
	output logic [7:0] in0,
	output logic [7:0] in1
);

	logic [NUM_SRC-1:0] up_v, down_v, left_v, right_v, fire_v;
	logic [7:0] in0_hi, in1_hi; // Active-high images

	// Interface arrays need constant indices
	for (genvar i = 0; i < NUM_SRC; i++) begin : g_flat
		assign up_v[i]    = lanes[i].up;
		assign down_v[i]  = lanes[i].down;
		assign left_v[i]  = lanes[i].left;
		assign right_v[i] = lanes[i].right;
		assign fire_v[i]  = lanes[i].fire;
	end

	always_comb begin
		in0_hi = 8'h00;
		in1_hi = 8'h00;
		in0_hi[in0_up]     = |up_v;
		in0_hi[in0_left]   = |left_v;
		in0_hi[in0_right]  = |right_v;
		in0_hi[in0_down]   = |down_v;
		in0_hi[in0_coin]   = kbd_coin;
		in1_hi[in1_fire]   = |fire_v;
		in1_hi[in1_start1] = kbd_start1;
		in1_hi[in1_start2] = kbd_start2;
	end

	// ========================================
	// Output registers, idle 8'hFF
	// ========================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			in0 <= 8'hFF;
			in1 <= 8'hFF;
		end else begin
			in0 <= ~in0_hi;
			in1 <= ~in1_hi;
		end
	end

	// Bit positions must stay inside the used masks
	a_unused_high: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(&(in0 | in0_used_mask)) && (&(in1 | in1_used_mask)));

endmodule

//--- src/ctl_pkg.sv
/*
 * Control package: keyboard scancodes, joystick bit positions,
 * control source indices and the default synchronizer depth
 */
package ctl_pkg;

	// ========================================
	// Keyboard scancodes (set 2 make codes)
	// ========================================
	localparam logic [7:0] sc_up     = 8'h75;
	localparam logic [7:0] sc_down   = 8'h72;
	localparam logic [7:0] sc_left   = 8'h6B;
	localparam logic [7:0] sc_right  = 8'h74;
	localparam logic [7:0] sc_coin   = 8'h76; // ESC
	localparam logic [7:0] sc_start1 = 8'h05; // F1
	localparam logic [7:0] sc_start2 = 8'h06; // F2
	localparam logic [7:0] sc_fire   = 8'h29; // Space

	// ========================================
	// Joystick word bit positions
	// ========================================
	localparam int joy_right = 0;
	localparam int joy_left  = 1;
	localparam int joy_down  = 2;
	localparam int joy_up    = 3;
	localparam int joy_fire  = 4;

	// Control sources
	// Keyboard first, then the joysticks in port order
	localparam int num_src  = 3;
	localparam int src_kbd  = 0;
	localparam int src_joy0 = 1; // joystick_1 follows at src_joy0 + 1

	// Joystick words come from another clock domain
	localparam int sync_stages_def = 2;

endpackage

//--- src/input_capture.sv
/*
 * Input capture: keyboard event decode into held button levels,
 * joystick synchronizers, one raw stick bundle per source
 */
`timescale 1ns/1ps

module input_capture import ctl_pkg::*; #(
	parameter int SYNC_STAGES = sync_stages_def
) (
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       key_strobe,
	input  logic       key_pressed,
	input  logic [7:0] key_code,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	stick_if.src       raw_stick [num_src],
	output logic       kbd_coin,
	output logic       kbd_start1,
	output logic       kbd_start2
);

	logic btn_up, btn_down, btn_left, btn_right, btn_fire;
	logic btn_coin, btn_start1, btn_start2;
	logic [7:0] joy_in [num_src-1];

	// ========================================
	// Keyboard
	// ========================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			btn_up     <= 1'b0;
			btn_down   <= 1'b0;
			btn_left   <= 1'b0;
			btn_right  <= 1'b0;
			btn_fire   <= 1'b0;
			btn_coin   <= 1'b0;
			btn_start1 <= 1'b0;
			btn_start2 <= 1'b0;
		end else if (key_strobe) begin
			case (key_code)
				sc_up:     btn_up     <= key_pressed;
				sc_down:   btn_down   <= key_pressed;
				sc_left:   btn_left   <= key_pressed;
				sc_right:  btn_right  <= key_pressed;
				sc_fire:   btn_fire   <= key_pressed;
				sc_coin:   btn_coin   <= key_pressed;
				sc_start1: btn_start1 <= key_pressed;
				sc_start2: btn_start2 <= key_pressed;
				default: ; // Unmapped keys ignored
			endcase
		end
	end

	// Buttons wait one stage, in step with the lane register
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			kbd_coin   <= 1'b0;
			kbd_start1 <= 1'b0;
			kbd_start2 <= 1'b0;
		end else begin
			kbd_coin   <= btn_coin;
			kbd_start1 <= btn_start1;
			kbd_start2 <= btn_start2;
		end
	end

	assign raw_stick[src_kbd].up    = btn_up;
	assign raw_stick[src_kbd].down  = btn_down;
	assign raw_stick[src_kbd].left  = btn_left;
	assign raw_stick[src_kbd].right = btn_right;
	assign raw_stick[src_kbd].fire  = btn_fire;

	// ========================================
	// Joysticks
	// ========================================
	assign joy_in[0] = joystick_0;
	assign joy_in[1] = joystick_1;

	for (genvar g = 0; g < num_src - 1; g++) begin : g_joy
		logic [7:0] sync_q [SYNC_STAGES];

		always_ff @(posedge clk_sys or negedge arst_n) begin
			if (!arst_n) begin
				for (int s = 0; s < SYNC_STAGES; s++)
					sync_q[s] <= 8'h00;
			end else begin
				sync_q[0] <= joy_in[g];
				for (int s = 1; s < SYNC_STAGES; s++)
					sync_q[s] <= sync_q[s-1];
			end
		end

		// Last stage feeds the bundle directly
		assign raw_stick[src_joy0 + g].up    = sync_q[SYNC_STAGES-1][joy_up];
		assign raw_stick[src_joy0 + g].down  = sync_q[SYNC_STAGES-1][joy_down];
		assign raw_stick[src_joy0 + g].left  = sync_q[SYNC_STAGES-1][joy_left];
		assign raw_stick[src_joy0 + g].right = sync_q[SYNC_STAGES-1][joy_right];
		assign raw_stick[src_joy0 + g].fire  = sync_q[SYNC_STAGES-1][joy_fire];
	end

	// A strobe must come with a fully known code, else the case above misses it
	a_key_code_known: assert property (@(posedge clk_sys) disable iff (!arst_n)
		key_strobe |-> !$isunknown({key_code, key_pressed}));

endmodule

//--- src/stick_if.sv
/*
 * Stick bundle of one control source
 * Four directions and fire, all active high
 */
`timescale 1ns/1ps

interface stick_if;

	logic up;
	logic down;
	logic left;
	logic right;
	logic fire;

	// Producer side
	modport src (output up, output down, output left, output right, output fire);

	// Consumer side
	modport dst (input up, input down, input left, input right, input fire);

endinterface

//--- src/stick_lane.sv
/*
 * Stick lane for one source: rotation remap for a turned screen,
 * opposing-direction suppression, output register
 */
`timescale 1ns/1ps

module stick_lane (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic rotate,
	stick_if.dst stick_in,
	stick_if.src stick_out
);

	logic rot_up, rot_down, rot_left, rot_right;
	logic q_up, q_down, q_left, q_right, q_fire;

	// Turned screen: stick rotated a quarter turn
	always_comb begin
		rot_up    = rotate ? stick_in.left  : stick_in.up;
		rot_down  = rotate ? stick_in.right : stick_in.down;
		rot_left  = rotate ? stick_in.down  : stick_in.left;
		rot_right = rotate ? stick_in.up    : stick_in.right;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			q_up    <= 1'b0;
			q_down  <= 1'b0;
			q_left  <= 1'b0;
			q_right <= 1'b0;
			q_fire  <= 1'b0;
		end else begin
			// Both of a pair held means neither
			q_up    <= rot_up & ~rot_down;
			q_down  <= rot_down & ~rot_up;
			q_left  <= rot_left & ~rot_right;
			q_right <= rot_right & ~rot_left;
			q_fire  <= stick_in.fire; // Never rotated
		end
	end

	assign stick_out.up    = q_up;
	assign stick_out.down  = q_down;
	assign stick_out.left  = q_left;
	assign stick_out.right = q_right;
	assign stick_out.fire  = q_fire;

	// The packer relies on each lane being clean on its own
	a_no_opposing: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(stick_out.up && stick_out.down) && !(stick_out.left && stick_out.right));

endmodule

//--- verif/tb_arcade_ctl.sv
/*
 * Testbench for arcade_ctl_top: clock, reset, stimulus,
 * cabinet word reference model, assertions, watchdog
 */
`timescale 1ns/1ps

module tb_arcade_ctl import ctl_pkg::*, cab_pkg::*; ();

	localparam int clk_period  = 100;
	localparam int kbd_cycles  = 8 * 14 + 24 * 3 + 8 * 2 + 10;
	localparam int rand_cycles = 400;
	localparam int supp_cycles = 2 * 7 * 9 + 40;
	localparam int dac_values  = 6;
	localparam int dac_cycles  = (dac_values + 2) * 520;
	localparam int wd_cycles   = 10 + kbd_cycles + rand_cycles + supp_cycles + dac_cycles + 200;
	localparam logic [7:0] key_list [8] = '{sc_up, sc_down, sc_left, sc_right,
		sc_fire, sc_coin, sc_start1, sc_start2};

	logic clk_sys = 1'b0;
	logic arst_n, key_strobe, key_pressed, rotate, audio_out;
	logic [7:0] key_code, joystick_0, joystick_1, audio, in0, in1;
	string test_name = "reset";

	// Model state, key byte is {start2, start1, coin, fire, up, down, left, right}
	logic [7:0] kb_now, kb_d1, kb_d2;
	logic [7:0] j0_h [4];
	logic [7:0] j1_h [4];
	logic rot_h0, rot_h1;
	logic [15:0] exp_cab;
	int dac_ones;
	logic [7:0] dac_exp;
	logic dac_check = 1'b0;

	always #(clk_period / 2) clk_sys = ~clk_sys;

	arcade_ctl_top u_dut (.clk_sys(clk_sys), .arst_n(arst_n), .key_strobe(key_strobe),
		.key_pressed(key_pressed), .key_code(key_code), .joystick_0(joystick_0),
		.joystick_1(joystick_1), .rotate(rotate), .audio(audio), .in0(in0), .in1(in1),
		.audio_out(audio_out));

	// ========================================
	// Reference model
	// ========================================
	function automatic logic [7:0] key_update(input logic [7:0] kb, input logic [7:0] code,
		input logic pressed);
		case (code)
			sc_right:  kb[0] = pressed;
			sc_left:   kb[1] = pressed;
			sc_down:   kb[2] = pressed;
			sc_up:     kb[3] = pressed;
			sc_fire:   kb[4] = pressed;
			sc_coin:   kb[5] = pressed;
			sc_start1: kb[6] = pressed;
			sc_start2: kb[7] = pressed;
			default: ;
		endcase
		return kb;
	endfunction

	// d is {up, down, left, right}
	function automatic logic [3:0] lane_dirs(input logic [3:0] d, input logic rot);
		logic [3:0] r;
		r = rot ? {d[1], d[0], d[2], d[3]} : d;
		if (r[3] && r[2]) r[3:2] = 2'b00;
		if (r[1] && r[0]) r[1:0] = 2'b00;
		return r;
	endfunction

	function automatic logic [15:0] expected_cab(input logic [7:0] kb, input logic [7:0] j0,
		input logic [7:0] j1, input logic rot);
		logic [3:0] m;
		logic [7:0] i0, i1;
		m = lane_dirs(kb[3:0], rot)
			| lane_dirs({j0[joy_up], j0[joy_down], j0[joy_left], j0[joy_right]}, rot)
			| lane_dirs({j1[joy_up], j1[joy_down], j1[joy_left], j1[joy_right]}, rot);
		i0 = 8'hFF;
		i1 = 8'hFF;
		i0[in0_up]     = ~m[3];
		i0[in0_down]   = ~m[2];
		i0[in0_left]   = ~m[1];
		i0[in0_right]  = ~m[0];
		i0[in0_coin]   = ~kb[5];
		i1[in1_fire]   = ~(kb[4] | j0[joy_fire] | j1[joy_fire]);
		i1[in1_start1] = ~kb[6];
		i1[in1_start2] = ~kb[7];
		return {i1, i0};
	endfunction

	// Keys 3 cycles, joysticks 4, rotate 2
	always @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			kb_now <= '0;
			kb_d1  <= '0;
			kb_d2  <= '0;
			rot_h0 <= 1'b0;
			rot_h1 <= 1'b0;
			for (int k = 0; k < 4; k++) begin
				j0_h[k] <= '0;
				j1_h[k] <= '0;
			end
		end else begin
			if (key_strobe) kb_now <= key_update(kb_now, key_code, key_pressed);
			kb_d1     <= kb_now;
			kb_d2     <= kb_d1;
			j0_h[0]   <= joystick_0;
			j1_h[0]   <= joystick_1;
			for (int k = 1; k < 4; k++) begin
				j0_h[k] <= j0_h[k-1];
				j1_h[k] <= j1_h[k-1];
			end
			rot_h0 <= rotate;
			rot_h1 <= rot_h0;
		end
	end

	assign exp_cab = expected_cab(kb_d2, j0_h[3], j1_h[3], rot_h1);

	// ========================================
	// Checks
	// ========================================
	a_reset_idle: assert property (@(negedge clk_sys)
		!arst_n |-> (in0 == 8'hFF && in1 == 8'hFF && !audio_out)) else begin
		$display("mismatch %s expected ffff_0 actual %h%h_%b", test_name,
			$sampled(in1), $sampled(in0), $sampled(audio_out));
		$display("** FAIL **");
		$fatal(1, "outputs not idle in reset");
	end

	a_cab_match: assert property (@(posedge clk_sys) disable iff (!arst_n)
		{in1, in0} == exp_cab) else begin
		$display("mismatch %s expected %h actual %h", test_name, $sampled(exp_cab),
			$sampled({in1, in0}));
		$display("** FAIL **");
		$fatal(1, "cabinet word differs from model");
	end

	a_dac_density: assert property (@(posedge clk_sys)
		dac_check |-> dac_ones == int'(dac_exp)) else begin
		$display("mismatch %s expected %0d actual %0d", test_name, $sampled(dac_exp),
			$sampled(dac_ones));
		$display("** FAIL **");
		$fatal(1, "DAC ones count wrong");
	end

	// ========================================
	// Stimulus
	// ========================================
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic key_event(input logic [7:0] code, input logic pressed);
		@(posedge clk_sys);
		key_strobe  <= 1'b1;
		key_code    <= code;
		key_pressed <= pressed;
		@(posedge clk_sys);
		key_strobe <= 1'b0;
	endtask

	task automatic hold_sticks(input logic [7:0] j0, input logic [7:0] j1, input logic rot);
		@(posedge clk_sys);
		joystick_0 <= j0;
		joystick_1 <= j1;
		rotate     <= rot;
		wait_cycles(8);
	endtask

	task automatic measure_density(input logic [7:0] val);
		int ones;
		ones = 0;
		@(posedge clk_sys);
		audio <= val;
		wait_cycles(258); // Settle
		repeat (256) begin
			@(posedge clk_sys);
			if (audio_out) ones++;
		end
		dac_ones  <= ones;
		dac_exp   <= val;
		dac_check <= 1'b1;
		@(posedge clk_sys);
		dac_check <= 1'b0;
	endtask

	initial begin
		logic [7:0] code;
		void'($urandom(32'h37fa_7d2f));
		arst_n      = 1'b0;
		key_strobe  = 1'b0;
		key_pressed = 1'b0;
		key_code    = 8'h00;
		joystick_0  = 8'h00;
		joystick_1  = 8'h00;
		rotate      = 1'b0;
		audio       = 8'h00;
		wait_cycles(5);
		arst_n <= 1'b1;
		wait_cycles(4);

		test_name = "keyboard";
		for (int i = 0; i < 8; i++) begin
			key_event(key_list[i], 1'b1);
			wait_cycles(5);
			key_event(key_list[i], 1'b0);
			wait_cycles(5);
		end
		key_event(sc_coin, 1'b1); // Held while unmapped codes arrive
		for (int i = 0; i < 24; i++) begin
			code = 8'($urandom);
			if (code == sc_up || code == sc_down || code == sc_left || code == sc_right
				|| code == sc_fire || code == sc_coin || code == sc_start1
				|| code == sc_start2)
				code = 8'h00;
			key_event(code, 1'($urandom));
			wait_cycles(1);
		end
		key_event(sc_coin, 1'b0);

		test_name = "merge";
		repeat (rand_cycles) begin
			@(posedge clk_sys);
			joystick_0  <= 8'($urandom);
			joystick_1  <= 8'($urandom);
			key_strobe  <= ($urandom % 6 == 0);
			key_code    <= key_list[3'($urandom)];
			key_pressed <= 1'($urandom);
			if ($urandom % 8 == 0) rotate <= ~rotate;
		end
		@(posedge clk_sys);
		key_strobe <= 1'b0;
		for (int i = 0; i < 8; i++) key_event(key_list[i], 1'b0);

		// Pairs on one source, then split over two
		test_name = "suppress";
		for (int r = 0; r < 2; r++) begin
			hold_sticks(8'h0C, 8'h00, 1'(r));
			hold_sticks(8'h03, 8'h00, 1'(r));
			hold_sticks(8'h0F, 8'h10, 1'(r));
			hold_sticks(8'h08, 8'h04, 1'(r));
			hold_sticks(8'h02, 8'h01, 1'(r));
			hold_sticks(8'h0C, 8'h03, 1'(r));
			hold_sticks(8'h00, 8'h00, 1'(r));
		end
		key_event(sc_up, 1'b1);
		key_event(sc_down, 1'b1);
		hold_sticks(8'h04, 8'h00, 1'b0);
		key_event(sc_up, 1'b0);
		key_event(sc_down, 1'b0);
		wait_cycles(6);

		test_name = "dac";
		measure_density(8'h00);
		measure_density(8'hFF);
		repeat (dac_values) measure_density(8'($urandom));

		$display("** PASS **");
		$finish;
	end

	// Watchdog
	initial begin
		#(wd_cycles * clk_period);
		$display("timeout: run did not finish within %0d clock cycles", wd_cycles);
		$display("** FAIL **");
		$fatal(1, "watchdog expired");
	end

endmodule
